// ==== design/cfg_rom.sv ====
`timescale 1ns/1ps

module cfg_rom (
    input  logic                        clk,
    input  hdmi_rx_cfg_pkg::rom_index_t rom_idx,
    output hdmi_rx_cfg_pkg::cfg_word_t  entry
);

    always_ff @(posedge clk)
    begin
        case (rom_idx)
            // init segment
            5'd0:  entry <= {16'h0204, 8'h02};
            5'd1:  entry <= {16'h0205, 8'h40};
            5'd2:  entry <= {16'h0004, 8'h01};
            5'd3:  entry <= {16'h0009, 8'h26};
            5'd4:  entry <= {16'h102E, 8'h01};
            5'd5:  entry <= {16'h1025, 8'hB0};
            5'd6:  entry <= {16'h102D, 8'h83};
            5'd7:  entry <= {16'h1000, 8'h20};
            5'd8:  entry <= {16'h100F, 8'h04};
            5'd9:  entry <= {16'h0003, 8'hC3};
            5'd10: entry <= {16'h103B, 8'h02};
            5'd11: entry <= {16'h00E1, 8'h00};
            5'd12: entry <= {16'h00A8, 8'h08};
            5'd13: entry <= {16'h000A, 8'h00};
            5'd14: entry <= {16'h0016, 8'h02};
            5'd15: entry <= {16'h00E2, 8'h01};
            5'd16: entry <= {16'h00C2, 8'h14};
            // second pass on 0x102d after clock setup
            5'd17: entry <= {16'h102D, 8'hC7};
            5'd18: entry <= {16'h1005, 8'h04};
            5'd19: entry <= {16'h1003, 8'h14};
            5'd20: entry <= {16'h1004, 8'h01};
            5'd21: entry <= {16'h1000, 8'h60};
            5'd22: entry <= {16'h1020, 8'h13};
            5'd23: entry <= {16'h1021, 8'h04};
            // post-lock segment
            5'd24: entry <= {16'h1010, 8'h01};
            5'd25: entry <= {16'h1024, 8'h00};
            5'd26: entry <= {16'h0200, 8'h00};
            5'd27: entry <= {16'h1024, 8'h70};
            5'd28: entry <= {16'h0200, 8'h07};
            // pulse on 0x0215
            5'd29: entry <= {16'h0215, 8'h01};
            5'd30: entry <= {16'h0215, 8'h00};
            default: entry <= '0;
        endcase
    end

endmodule

// ==== design/cfg_sequencer.sv ====
`timescale 1ns/1ps

module cfg_sequencer (
    input  logic                        clk,
    input  logic                        rstn,
    input  hdmi_rx_cfg_pkg::i2c_rsp_t   rsp,
    input  logic                        locked,
    input  hdmi_rx_cfg_pkg::cfg_word_t  entry,
    output hdmi_rx_cfg_pkg::rom_index_t rom_idx,
    output logic                        poll_start,
    output logic                        iic_trig,
    output hdmi_rx_cfg_pkg::i2c_req_t   req,
    output logic                        init_over
);

    hdmi_rx_cfg_pkg::cfg_state_t state;
    logic                        busy_q;
    logic                        busy_fall;
    logic                        fall_q;
    logic                        armed;
    logic                        kick_q;
    logic [7:0]                  rd_byte;
    logic                        last_init;
    logic                        last_post;

    function automatic hdmi_rx_cfg_pkg::i2c_req_t make_req(
        input logic        wr,
        input logic [15:0] addr,
        input logic [7:0]  data
    );
        hdmi_rx_cfg_pkg::i2c_req_t r;
        r.wr   = wr;
        r.addr = addr;
        r.data = data;
        return r;
    endfunction

    assign busy_fall = busy_q & ~rsp.busy;

    // rom_idx already points past the entry just written
    assign last_init = (rom_idx == hdmi_rx_cfg_pkg::INIT_LEN);
    assign last_post = (rom_idx == hdmi_rx_cfg_pkg::TABLE_LEN);

    // end of transaction one cycle after busy is seen low
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            busy_q <= 1'b0;
            fall_q <= 1'b0;
            armed  <= 1'b0;
            kick_q <= 1'b0;
        end
        else
        begin
            busy_q <= rsp.busy;
            fall_q <= busy_fall;
            armed  <= 1'b1;
            kick_q <= ~armed;
        end
    end

    // last read byte for the link check
    always_ff @(posedge clk)
    begin
        if (rsp.byte_over)
            rd_byte <= rsp.rdata;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state      <= hdmi_rx_cfg_pkg::CHK_WR;
            rom_idx    <= '0;
            iic_trig   <= 1'b0;
            poll_start <= 1'b0;
            init_over  <= 1'b0;
            req        <= make_req(1'b1, hdmi_rx_cfg_pkg::CHK_ADDR, hdmi_rx_cfg_pkg::CHK_DATA);
        end
        else
        begin
            iic_trig   <= 1'b0;
            poll_start <= 1'b0;
            if (kick_q)
                // check write is preloaded by reset
                iic_trig <= 1'b1;
            else if (fall_q)
            begin
                case (state)
                    hdmi_rx_cfg_pkg::CHK_WR:
                    begin
                        state    <= hdmi_rx_cfg_pkg::CHK_RD;
                        iic_trig <= 1'b1;
                        req      <= make_req(1'b0, hdmi_rx_cfg_pkg::CHK_ADDR, 8'h00);
                    end
                    hdmi_rx_cfg_pkg::CHK_RD:
                    begin
                        iic_trig <= 1'b1;
                        if (rd_byte == hdmi_rx_cfg_pkg::CHK_DATA)
                        begin
                            state   <= hdmi_rx_cfg_pkg::INIT;
                            req     <= make_req(1'b1, entry.addr, entry.data);
                            rom_idx <= rom_idx + 5'd1;
                        end
                        else
                        begin
                            // link not up yet so write the scratch byte again
                            state <= hdmi_rx_cfg_pkg::CHK_WR;
                            req   <= make_req(1'b1, hdmi_rx_cfg_pkg::CHK_ADDR,
                                              hdmi_rx_cfg_pkg::CHK_DATA);
                        end
                    end
                    hdmi_rx_cfg_pkg::INIT:
                    begin
                        iic_trig <= 1'b1;
                        if (last_init)
                        begin
                            state      <= hdmi_rx_cfg_pkg::POLL;
                            poll_start <= 1'b1;
                            req        <= make_req(1'b0, hdmi_rx_cfg_pkg::STAT_ADDR, 8'h00);
                        end
                        else
                        begin
                            req     <= make_req(1'b1, entry.addr, entry.data);
                            rom_idx <= rom_idx + 5'd1;
                        end
                    end
                    hdmi_rx_cfg_pkg::POLL:
                    begin
                        iic_trig <= 1'b1;
                        if (locked)
                        begin
                            state   <= hdmi_rx_cfg_pkg::POST;
                            req     <= make_req(1'b1, entry.addr, entry.data);
                            rom_idx <= rom_idx + 5'd1;
                        end
                        else
                        begin
                            poll_start <= 1'b1;
                            req        <= make_req(1'b0, hdmi_rx_cfg_pkg::STAT_ADDR, 8'h00);
                        end
                    end
                    hdmi_rx_cfg_pkg::POST:
                    begin
                        if (last_post)
                        begin
                            state     <= hdmi_rx_cfg_pkg::DONE;
                            init_over <= 1'b1;
                        end
                        else
                        begin
                            iic_trig <= 1'b1;
                            req      <= make_req(1'b1, entry.addr, entry.data);
                            rom_idx  <= rom_idx + 5'd1;
                        end
                    end
                    default:
                    begin
                        state <= hdmi_rx_cfg_pkg::DONE;
                    end
                endcase
            end
        end
    end

endmodule

// ==== design/freq_lock_detect.sv ====
`timescale 1ns/1ps

module freq_lock_detect (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      poll_start,
    input  hdmi_rx_cfg_pkg::i2c_rsp_t rsp,
    output logic                      locked
);

    logic [8*hdmi_rx_cfg_pkg::STAT_BYTES-1:0] word;
    logic [8*hdmi_rx_cfg_pkg::STAT_BYTES-1:0] prev_word;
    logic                                     busy_q;
    logic                                     busy_fall;
    logic                                     active;
    logic [1:0]                               new_field;
    logic [1:0]                               old_field;

    assign busy_fall = busy_q & ~rsp.busy;
    assign new_field = word[hdmi_rx_cfg_pkg::LOCK_LSB +: 2];
    assign old_field = prev_word[hdmi_rx_cfg_pkg::LOCK_LSB +: 2];

    // status bytes arrive low byte first
    always_ff @(posedge clk)
    begin
        if (poll_start)
            word <= '0;
        else if (active && rsp.byte_over)
            word <= {rsp.rdata, word[8*hdmi_rx_cfg_pkg::STAT_BYTES-1:8]};
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            busy_q    <= 1'b0;
            active    <= 1'b0;
            locked    <= 1'b0;
            prev_word <= '0;
        end
        else
        begin
            busy_q <= rsp.busy;
            locked <= 1'b0;
            if (poll_start)
                active <= 1'b1;
            else if (active && busy_fall)
            begin
                active    <= 1'b0;
                prev_word <= word;
                // only the idle to ok step counts as lock
                locked    <= (old_field == hdmi_rx_cfg_pkg::LOCK_IDLE) &&
                             (new_field == hdmi_rx_cfg_pkg::LOCK_OK);
            end
        end
    end

endmodule

// ==== design/hdmi_rx_cfg_pkg.sv ====
package hdmi_rx_cfg_pkg;

    // receiver i2c address and link check
    localparam logic [7:0]  DEVICE_ID = 8'h56;
    localparam logic [15:0] CHK_ADDR  = 16'h0003;
    localparam logic [7:0]  CHK_DATA  = 8'h5A;

    // frequency status polling
    localparam logic [15:0] STAT_ADDR  = 16'h0000;
    localparam int          STAT_BYTES = 4;
    localparam int          LOCK_LSB   = 16;
    localparam logic [1:0]  LOCK_IDLE  = 2'b00;
    localparam logic [1:0]  LOCK_OK    = 2'b10;

    typedef logic [4:0] rom_index_t;

    localparam rom_index_t INIT_LEN  = 5'd24;
    localparam rom_index_t POST_LEN  = 5'd7;
    localparam rom_index_t TABLE_LEN = INIT_LEN + POST_LEN;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
    } cfg_word_t;

    // wr = 1 for write, 0 for read
    typedef struct packed {
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  data;
    } i2c_req_t;

    typedef struct packed {
        logic       busy;
        logic       byte_over;
        logic [7:0] rdata;
    } i2c_rsp_t;

    typedef enum logic [2:0] {
        CHK_WR,
        CHK_RD,
        INIT,
        POLL,
        POST,
        DONE
    } cfg_state_t;

endpackage

// ==== design/hdmi_rx_cfg_top.sv ====
`timescale 1ns/1ps

module hdmi_rx_cfg_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  hdmi_rx_cfg_pkg::i2c_rsp_t rsp,
    output logic                      iic_trig,
    output hdmi_rx_cfg_pkg::i2c_req_t req,
    output logic [7:0]                device_id,
    output logic                      init_over
);

    hdmi_rx_cfg_pkg::rom_index_t rom_idx;
    hdmi_rx_cfg_pkg::cfg_word_t  entry;
    logic                        poll_start;
    logic                        locked;

    // fixed receiver address
    assign device_id = hdmi_rx_cfg_pkg::DEVICE_ID;

    cfg_sequencer u_seq (
        .clk        (clk),
        .rstn       (rstn),
        .rsp        (rsp),
        .locked     (locked),
        .entry      (entry),
        .rom_idx    (rom_idx),
        .poll_start (poll_start),
        .iic_trig   (iic_trig),
        .req        (req),
        .init_over  (init_over)
    );

    cfg_rom u_rom (
        .clk     (clk),
        .rom_idx (rom_idx),
        .entry   (entry)
    );

    freq_lock_detect u_lock (
        .clk        (clk),
        .rstn       (rstn),
        .poll_start (poll_start),
        .rsp        (rsp),
        .locked     (locked)
    );

endmodule

// ==== sim.f ====
design/hdmi_rx_cfg_pkg.sv
design/cfg_rom.sv
design/freq_lock_detect.sv
design/cfg_sequencer.sv
design/hdmi_rx_cfg_top.sv
sim/i2c_target_model.sv
sim/tb_hdmi_rx_cfg.sv

// ==== sim/i2c_target_model.sv ====
`timescale 1ns/1ps

module i2c_target_model (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      iic_trig,
    input  hdmi_rx_cfg_pkg::i2c_req_t req,
    input  int                        bad_checks,
    input  int                        unlocked_polls,
    output hdmi_rx_cfg_pkg::i2c_rsp_t rsp
);

    int check_reads;
    int status_reads;

    // busy for a random time, then one byte per cycle, then busy drops
    task automatic serve(input hdmi_rx_cfg_pkg::i2c_req_t r);
        int          len;
        int          nbytes;
        logic [31:0] word;
        len    = 2 + ($urandom % 8);
        nbytes = 0;
        word   = $urandom;
        if (!r.wr && r.addr == hdmi_rx_cfg_pkg::CHK_ADDR)
        begin
            nbytes = 1;
            if (check_reads < bad_checks)
            begin
                // any byte but the check value
                if (word[7:0] == hdmi_rx_cfg_pkg::CHK_DATA)
                    word[0] = ~word[0];
            end
            else
                word[7:0] = hdmi_rx_cfg_pkg::CHK_DATA;
            check_reads++;
        end
        else if (!r.wr)
        begin
            nbytes = hdmi_rx_cfg_pkg::STAT_BYTES;
            if (status_reads < unlocked_polls)
                word[hdmi_rx_cfg_pkg::LOCK_LSB +: 2] = hdmi_rx_cfg_pkg::LOCK_IDLE;
            else
                word[hdmi_rx_cfg_pkg::LOCK_LSB +: 2] = hdmi_rx_cfg_pkg::LOCK_OK;
            status_reads++;
        end
        rsp.busy = 1'b1;
        repeat (len) @(negedge clk);
        for (int i = 0; i < nbytes; i++)
        begin
            rsp.byte_over = 1'b1;
            rsp.rdata     = word[8*i +: 8];
            @(negedge clk);
        end
        rsp.byte_over = 1'b0;
        rsp.busy      = 1'b0;
    endtask

    initial
    begin
        rsp          = '0;
        check_reads  = 0;
        status_reads = 0;
        forever
        begin
            @(negedge clk);
            if (rstn && iic_trig)
                serve(req);
        end
    end

endmodule

// ==== sim/tb_hdmi_rx_cfg.sv ====
`timescale 1ns/1ps

module tb_hdmi_rx_cfg;

    logic                      clk;
    logic                      rstn;
    hdmi_rx_cfg_pkg::i2c_rsp_t rsp;
    logic                      iic_trig;
    hdmi_rx_cfg_pkg::i2c_req_t req;
    logic [7:0]                device_id;
    logic                      init_over;

    int                         seed;
    int                         bad_checks;
    int                         unlocked_polls;
    int                         mismatches;
    int                         failures;
    int                         trig_count;
    int                         rd_cnt;
    logic                       aborted;
    logic                       busy_prev;
    logic                       cur_wr;
    logic [31:0]                rd_word;
    hdmi_rx_cfg_pkg::cfg_word_t table_ref [31];
    hdmi_rx_cfg_pkg::i2c_req_t  req_q [$];
    logic [31:0]                rd_q [$];

    hdmi_rx_cfg_top uut (
        .clk       (clk),
        .rstn      (rstn),
        .rsp       (rsp),
        .iic_trig  (iic_trig),
        .req       (req),
        .device_id (device_id),
        .init_over (init_over)
    );

    i2c_target_model u_target (
        .clk            (clk),
        .rstn           (rstn),
        .iic_trig       (iic_trig),
        .req            (req),
        .bad_checks     (bad_checks),
        .unlocked_polls (unlocked_polls),
        .rsp            (rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // request log and read data assembly with the first byte lowest
    always @(posedge clk)
    begin
        if (!rstn)
            busy_prev = 1'b0;
        else
        begin
            if (iic_trig)
            begin
                if (busy_prev)
                begin
                    failures++;
                    $display("trigger at %0t while the previous transaction was busy", $time);
                end
                req_q.push_back(req);
                trig_count++;
                cur_wr  = req.wr;
                rd_cnt  = 0;
                rd_word = '0;
            end
            if (rsp.byte_over && rd_cnt < 4)
            begin
                rd_word[8*rd_cnt +: 8] = rsp.rdata;
                rd_cnt++;
            end
            if (busy_prev && !rsp.busy && !cur_wr)
                rd_q.push_back(rd_word);
            busy_prev = rsp.busy;
        end
    end

    function automatic hdmi_rx_cfg_pkg::i2c_req_t build_req(input logic wr,
        input logic [15:0] addr, input logic [7:0] data);
        hdmi_rx_cfg_pkg::i2c_req_t r;
        r.wr   = wr;
        r.addr = addr;
        r.data = data;
        return r;
    endfunction

    task automatic check_req(input string what, input hdmi_rx_cfg_pkg::i2c_req_t exp,
        input hdmi_rx_cfg_pkg::i2c_req_t got);
        hdmi_rx_cfg_pkg::i2c_req_t g;
        g = got;
        // data byte of a read is don't care
        if (!g.wr)
            g.data = exp.data;
        if (g !== exp)
        begin
            mismatches++;
            $display("mismatch at %0t: req (%s) expected %0b/%h/%h got %0b/%h/%h",
                     $time, what, exp.wr, exp.addr, exp.data, got.wr, got.addr, got.data);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp)
        begin
            mismatches++;
            $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp)
        begin
            mismatches++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic expect_req(input string what, input hdmi_rx_cfg_pkg::i2c_req_t exp);
        int n;
        n = 0;
        while (req_q.size() == 0 && n < 400)
        begin
            @(posedge clk);
            n++;
        end
        if (req_q.size() == 0)
        begin
            failures++;
            aborted = 1'b1;
            $display("no %s request arrived within 400 cycles at %0t", what, $time);
        end
        else
            check_req(what, exp, req_q.pop_front());
    endtask

    task automatic next_read(output logic [31:0] word);
        int n;
        n    = 0;
        word = '0;
        while (rd_q.size() == 0 && n < 400)
        begin
            @(posedge clk);
            n++;
        end
        if (rd_q.size() == 0)
        begin
            failures++;
            aborted = 1'b1;
            $display("read data never completed within 400 cycles at %0t", $time);
        end
        else
            word = rd_q.pop_front();
    endtask

    task automatic run_sequence();
        logic [31:0] word;
        logic [1:0]  prev_field;
        logic [1:0]  new_field;
        logic        good;
        logic        lock_seen;
        logic        stayed;
        int          bad_seen;
        int          polls;
        int          n;
        good     = 1'b0;
        bad_seen = 0;
        // link check is retried after each bad read
        while (!good && bad_seen <= 3)
        begin
            expect_req("check write",
                       build_req(1'b1, hdmi_rx_cfg_pkg::CHK_ADDR, hdmi_rx_cfg_pkg::CHK_DATA));
            if (aborted)
                return;
            expect_req("check read", build_req(1'b0, hdmi_rx_cfg_pkg::CHK_ADDR, 8'h00));
            if (aborted)
                return;
            next_read(word);
            if (aborted)
                return;
            good = (word[7:0] == hdmi_rx_cfg_pkg::CHK_DATA);
            if (!good)
                bad_seen++;
        end
        for (int i = 0; i < hdmi_rx_cfg_pkg::INIT_LEN; i++)
        begin
            expect_req("init write", build_req(1'b1, table_ref[i].addr, table_ref[i].data));
            if (aborted)
                return;
        end
        // lock is the idle to ok step between two status words
        prev_field = hdmi_rx_cfg_pkg::LOCK_IDLE;
        lock_seen  = 1'b0;
        polls      = 0;
        while (!lock_seen && polls < 8)
        begin
            expect_req("status read", build_req(1'b0, hdmi_rx_cfg_pkg::STAT_ADDR, 8'h00));
            if (aborted)
                return;
            next_read(word);
            if (aborted)
                return;
            new_field  = word[hdmi_rx_cfg_pkg::LOCK_LSB +: 2];
            lock_seen  = (prev_field == hdmi_rx_cfg_pkg::LOCK_IDLE) &&
                         (new_field == hdmi_rx_cfg_pkg::LOCK_OK);
            prev_field = new_field;
            polls++;
        end
        for (int i = hdmi_rx_cfg_pkg::INIT_LEN; i < hdmi_rx_cfg_pkg::TABLE_LEN; i++)
        begin
            expect_req("post write", build_req(1'b1, table_ref[i].addr, table_ref[i].data));
            if (aborted)
                return;
        end
        n = 0;
        while (init_over !== 1'b1 && n < 100)
        begin
            @(posedge clk);
            n++;
        end
        check_bit("init_over", 1'b1, init_over);
        stayed = 1'b1;
        repeat (500)
        begin
            @(posedge clk);
            if (init_over !== 1'b1)
                stayed = 1'b0;
        end
        check_bit("init_over held", 1'b1, stayed);
        if (req_q.size() != 0)
        begin
            failures++;
            $display("%0d requests issued after init_over", req_q.size());
        end
    endtask

    initial
    begin
        rstn       = 1'b0;
        mismatches = 0;
        failures   = 0;
        trig_count = 0;
        aborted    = 1'b0;
        busy_prev  = 1'b0;
        cur_wr     = 1'b1;
        rd_cnt     = 0;
        rd_word    = '0;
        seed       = 32'h617705a2;
        bad_checks     = $urandom(seed) % 3;
        unlocked_polls = 1 + ($urandom % 5);
        // receiver register table as {addr, data}
        table_ref = '{24'h0204_02, 24'h0205_40, 24'h0004_01, 24'h0009_26, 24'h102E_01,
                      24'h1025_B0, 24'h102D_83, 24'h1000_20, 24'h100F_04, 24'h0003_C3,
                      24'h103B_02, 24'h00E1_00, 24'h00A8_08, 24'h000A_00, 24'h0016_02,
                      24'h00E2_01, 24'h00C2_14, 24'h102D_C7, 24'h1005_04, 24'h1003_14,
                      24'h1004_01, 24'h1000_60, 24'h1020_13, 24'h1021_04, 24'h1010_01,
                      24'h1024_00, 24'h0200_00, 24'h1024_70, 24'h0200_07, 24'h0215_01,
                      24'h0215_00};
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        check_bit("iic_trig", 1'b0, iic_trig);
        check_bit("init_over", 1'b0, init_over);
        check_byte("device_id", hdmi_rx_cfg_pkg::DEVICE_ID, device_id);
        run_sequence();
        $display("errors: %0d mismatches, %0d other failures, %0d requests seen",
                 mismatches, failures, trig_count);
        if (mismatches == 0 && failures == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
